// ==== Bender.yml ====
package:
  name: tlb

sources:
  - source/tlb_pkg.sv
  - source/tlb_array.sv
  - source/tlb_lookup.sv
  - source/tlb_op_fsm.sv
  - source/tlb_fill_counter.sv
  - source/tlb_top.sv
  - target: simulation
    files:
      - verification/tlb_tb.sv

// ==== list.f ====
source/tlb_pkg.sv
source/tlb_array.sv
source/tlb_lookup.sv
source/tlb_op_fsm.sv
source/tlb_fill_counter.sv
source/tlb_top.sv
verification/tlb_tb.sv

// ==== source/tlb_array.sv ====
`timescale 1ns/1ps

module tlb_array (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   wr_en,
    input  logic [tlb_pkg::TLB_IDX_W-1:0]          wr_index,
    input  tlb_pkg::tlb_entry_t                    wr_entry,
    input  logic                                   inv_en,
    input  tlb_pkg::tlb_inv_sel_t                  inv_sel,
    input  logic [tlb_pkg::TLB_IDX_W-1:0]          rd_index,
    output tlb_pkg::tlb_entry_t                    rd_entry,
    output tlb_pkg::tlb_store_t [tlb_pkg::TLB_NUM-1:0] entries
);

    // valid bits live apart from the payload
    logic [tlb_pkg::TLB_NUM-1:0] e_q;
    tlb_pkg::tlb_store_t         data_q [tlb_pkg::TLB_NUM];

    tlb_pkg::tlb_store_t         wr_store;
    tlb_pkg::tlb_store_t         rd_store;

    logic [tlb_pkg::TLB_NUM-1:0] is_global;
    logic [tlb_pkg::TLB_NUM-1:0] asid_hit;
    logic [tlb_pkg::TLB_NUM-1:0] vppn_hit;
    logic [tlb_pkg::TLB_NUM-1:0] inv_mask;

    // anything but 4 MB is kept as 4 KB
    always_comb begin
        wr_store       = '0;
        wr_store.e     = wr_entry.e;
        wr_store.vppn  = wr_entry.vppn;
        wr_store.ps4m  = (wr_entry.ps == tlb_pkg::PS_4M);
        wr_store.asid  = wr_entry.asid;
        wr_store.g     = wr_entry.g;
        wr_store.page0 = wr_entry.page0;
        wr_store.page1 = wr_entry.page1;
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_q[wr_index] <= wr_store;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            e_q <= '0;
        end else if (wr_en) begin
            e_q[wr_index] <= wr_entry.e;
        end else if (inv_en) begin
            e_q <= e_q & ~inv_mask;
        end
    end

    always_comb begin
        for (int i = 0; i < tlb_pkg::TLB_NUM; i++) begin
            entries[i]   = data_q[i];
            entries[i].e = e_q[i];
        end
    end

    // per-entry terms for the INVTLB mask
    always_comb begin
        for (int i = 0; i < tlb_pkg::TLB_NUM; i++) begin
            is_global[i] = entries[i].g;
            asid_hit[i]  = (entries[i].asid == inv_sel.asid);
            vppn_hit[i]  = (entries[i].vppn[18:9] == inv_sel.vppn[18:9])
                        && (entries[i].ps4m || (entries[i].vppn[8:0] == inv_sel.vppn[8:0]));
        end
    end

    always_comb begin
        case (inv_sel.op)
            5'd0, 5'd1: inv_mask = '1;
            5'd2:       inv_mask = is_global;
            5'd3:       inv_mask = ~is_global;
            5'd4:       inv_mask = ~is_global & asid_hit;
            5'd5:       inv_mask = ~is_global & asid_hit & vppn_hit;
            5'd6:       inv_mask = (is_global | asid_hit) & vppn_hit;
            // undefined ops leave the TLB alone
            default:    inv_mask = '0;
        endcase
    end

    // indexed read with page size rebuilt from the flag
    always_comb begin
        rd_store       = entries[rd_index];
        rd_entry.e     = rd_store.e;
        rd_entry.vppn  = rd_store.vppn;
        rd_entry.ps    = rd_store.ps4m ? tlb_pkg::PS_4M : tlb_pkg::PS_4K;
        rd_entry.asid  = rd_store.asid;
        rd_entry.g     = rd_store.g;
        rd_entry.page0 = rd_store.page0;
        rd_entry.page1 = rd_store.page1;
    end

    // the op FSM issues one array update per command
    a_wr_inv_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(wr_en && inv_en)
    ) else $error("write and invalidate issued in the same cycle");

endmodule

// ==== source/tlb_fill_counter.sv ====
`timescale 1ns/1ps

module tlb_fill_counter (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          adv,
    output logic [tlb_pkg::TLB_IDX_W-1:0] index
);

    // round robin over the slots
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            index <= '0;
        end else if (adv) begin
            if (index == tlb_pkg::TLB_IDX_W'(tlb_pkg::TLB_NUM - 1)) begin
                index <= '0;
            end else begin
                index <= index + 1'b1;
            end
        end
    end

endmodule

// ==== source/tlb_lookup.sv ====
`timescale 1ns/1ps

module tlb_lookup (
    input  tlb_pkg::tlb_store_t [tlb_pkg::TLB_NUM-1:0] entries,
    input  tlb_pkg::tlb_search_req_t               req,
    output tlb_pkg::tlb_search_rsp_t               rsp
);

    logic [tlb_pkg::TLB_NUM-1:0]   match;
    logic [tlb_pkg::TLB_IDX_W-1:0] hit_idx;
    tlb_pkg::tlb_store_t           hit;
    logic                          odd_page;

    always_comb begin
        for (int i = 0; i < tlb_pkg::TLB_NUM; i++) begin
            match[i] = entries[i].e
                    && (req.vppn[18:9] == entries[i].vppn[18:9])
                    && (entries[i].ps4m || (req.vppn[8:0] == entries[i].vppn[8:0]))
                    && (entries[i].g || (req.asid == entries[i].asid));
        end
    end

    // or-encode relying on at most one hit
    always_comb begin
        hit_idx = '0;
        for (int i = 0; i < tlb_pkg::TLB_NUM; i++) begin
            if (match[i]) begin
                hit_idx = hit_idx | i[tlb_pkg::TLB_IDX_W-1:0];
            end
        end
    end

    assign hit = entries[hit_idx];

    // 4 MB pairs split on vppn bit 8 and 4 KB pairs on va bit 12
    assign odd_page = hit.ps4m ? req.vppn[8] : req.va_bit12;

    always_comb begin
        rsp.found = |match;
        rsp.index = hit_idx;
        rsp.ps    = hit.ps4m ? tlb_pkg::PS_4M : tlb_pkg::PS_4K;
        rsp.page  = odd_page ? hit.page1 : hit.page0;
    end

    // duplicate mappings would make the encoded index garbage
    a_one_hit: assert final ($isunknown(match) || $onehot0(match))
        else $error("multiple TLB entries hit one request");

endmodule

// ==== source/tlb_op_fsm.sv ====
`timescale 1ns/1ps

module tlb_op_fsm (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cmd_req,
    input  tlb_pkg::tlb_cmd_t             cmd,
    input  tlb_pkg::tlb_search_rsp_t      srch_rsp,
    input  tlb_pkg::tlb_entry_t           rd_entry,
    input  logic [tlb_pkg::TLB_IDX_W-1:0] fill_index,
    output logic                          cmd_ack,
    output tlb_pkg::tlb_cmd_rsp_t         cmd_rsp,
    output tlb_pkg::tlb_search_req_t      srch_req,
    output logic                          wr_en,
    output logic [tlb_pkg::TLB_IDX_W-1:0] wr_index,
    output tlb_pkg::tlb_entry_t           wr_entry,
    output logic                          inv_en,
    output tlb_pkg::tlb_inv_sel_t         inv_sel,
    output logic [tlb_pkg::TLB_IDX_W-1:0] rd_index,
    output logic                          fill_adv
);

    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        ACK
    } state_t;

    state_t                state_q;
    tlb_pkg::tlb_cmd_t     cmd_q;
    tlb_pkg::tlb_cmd_rsp_t rsp_d;
    logic                  exec;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            cmd_ack <= 1'b0;
        end else begin
            case (state_q)
                IDLE: if (cmd_req) state_q <= EXEC;
                EXEC: state_q <= ACK;
                default: begin
                    // hold ack until the master lets go of req
                    if (cmd_ack) begin
                        if (!cmd_req) begin
                            cmd_ack <= 1'b0;
                            state_q <= IDLE;
                        end
                    end else if (cmd_req) begin
                        cmd_ack <= 1'b1;
                    end else begin
                        state_q <= IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && cmd_req) begin
            cmd_q <= cmd;
        end
        if (exec) begin
            cmd_rsp <= rsp_d;
        end
    end

    assign exec = (state_q == EXEC);

    // array controls straight from the latched command
    assign wr_en    = exec && (cmd_q.kind == tlb_pkg::WR || cmd_q.kind == tlb_pkg::FILL);
    assign wr_index = (cmd_q.kind == tlb_pkg::FILL) ? fill_index : cmd_q.arg.idx.index;
    assign wr_entry = cmd_q.entry;
    assign inv_en   = exec && (cmd_q.kind == tlb_pkg::INV);
    assign inv_sel  = cmd_q.arg.inv;
    assign rd_index = cmd_q.arg.idx.index;
    assign fill_adv = exec && (cmd_q.kind == tlb_pkg::FILL);

    // TLBSRCH key comes from the entry fields
    assign srch_req.vppn     = cmd_q.entry.vppn;
    assign srch_req.va_bit12 = 1'b0;
    assign srch_req.asid     = cmd_q.entry.asid;

    always_comb begin
        rsp_d       = '0;
        rsp_d.index = cmd_q.arg.idx.index;
        case (cmd_q.kind)
            tlb_pkg::SRCH: begin
                rsp_d.found = srch_rsp.found;
                rsp_d.index = srch_rsp.index;
            end
            tlb_pkg::RD:   rsp_d.entry = rd_entry;
            tlb_pkg::FILL: rsp_d.index = fill_index;
            default:       rsp_d.entry = cmd_q.entry;
        endcase
    end

    // ack only answers a req that was accepted in IDLE three edges before
    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(cmd_ack) |-> $past(cmd_req, 3)
    ) else $error("cmd_ack raised without a pending cmd_req");

endmodule

// ==== source/tlb_pkg.sv ====
package tlb_pkg;

    // TLB geometry
    localparam int TLB_NUM   = 16;
    localparam int TLB_IDX_W = $clog2(TLB_NUM);

    // page size codes as seen on the ports
    localparam logic [5:0] PS_4K = 6'd12;
    localparam logic [5:0] PS_4M = 6'd21;

    // width of the maintenance command operand
    localparam int CMD_ARG_W = 34;

    typedef struct packed {
        logic [19:0] ppn;
        logic [1:0]  plv;
        logic [1:0]  mat;
        logic        d;
        logic        v;
    } tlb_page_t;

    typedef struct packed {
        logic        e;
        logic [18:0] vppn;
        logic [5:0]  ps;
        logic [9:0]  asid;
        logic        g;
        tlb_page_t   page0;
        tlb_page_t   page1;
    } tlb_entry_t;

    // stored form with page size collapsed to one flag
    typedef struct packed {
        logic        e;
        logic [18:0] vppn;
        logic        ps4m;
        logic [9:0]  asid;
        logic        g;
        tlb_page_t   page0;
        tlb_page_t   page1;
    } tlb_store_t;

    typedef struct packed {
        logic [18:0] vppn;
        logic        va_bit12;
        logic [9:0]  asid;
    } tlb_search_req_t;

    typedef struct packed {
        logic                 found;
        logic [TLB_IDX_W-1:0] index;
        logic [5:0]           ps;
        tlb_page_t            page;
    } tlb_search_rsp_t;

    typedef enum logic [2:0] {
        SRCH,
        RD,
        WR,
        FILL,
        INV
    } tlb_cmd_kind_t;

    typedef struct packed {
        logic [4:0]  op;
        logic [9:0]  asid;
        logic [18:0] vppn;
    } tlb_inv_sel_t;

    typedef struct packed {
        logic [CMD_ARG_W-TLB_IDX_W-1:0] pad;
        logic [TLB_IDX_W-1:0]           index;
    } tlb_idx_arg_t;

    // operand is an entry index for RD/WR or an invalidate selector for INV
    typedef union packed {
        tlb_inv_sel_t inv;
        tlb_idx_arg_t idx;
    } tlb_cmd_arg_u;

    typedef struct packed {
        tlb_cmd_kind_t kind;
        tlb_cmd_arg_u  arg;
        tlb_entry_t    entry;
    } tlb_cmd_t;

    typedef struct packed {
        logic                 found;
        logic [TLB_IDX_W-1:0] index;
        tlb_entry_t           entry;
    } tlb_cmd_rsp_t;

endpackage

// ==== source/tlb_top.sv ====
`timescale 1ns/1ps

module tlb_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  tlb_pkg::tlb_search_req_t fetch_req,
    output tlb_pkg::tlb_search_rsp_t fetch_rsp,
    input  tlb_pkg::tlb_search_req_t data_req,
    output tlb_pkg::tlb_search_rsp_t data_rsp,
    input  logic                     cmd_req,
    input  tlb_pkg::tlb_cmd_t        cmd,
    output logic                     cmd_ack,
    output tlb_pkg::tlb_cmd_rsp_t    cmd_rsp
);

    tlb_pkg::tlb_store_t [tlb_pkg::TLB_NUM-1:0] entries;

    logic                          wr_en;
    logic [tlb_pkg::TLB_IDX_W-1:0] wr_index;
    tlb_pkg::tlb_entry_t           wr_entry;
    logic                          inv_en;
    tlb_pkg::tlb_inv_sel_t         inv_sel;
    logic [tlb_pkg::TLB_IDX_W-1:0] rd_index;
    tlb_pkg::tlb_entry_t           rd_entry;
    tlb_pkg::tlb_search_req_t      srch_req;
    tlb_pkg::tlb_search_rsp_t      srch_rsp;
    logic                          fill_adv;
    logic [tlb_pkg::TLB_IDX_W-1:0] fill_index;

    tlb_array array_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_entry (wr_entry),
        .inv_en   (inv_en),
        .inv_sel  (inv_sel),
        .rd_index (rd_index),
        .rd_entry (rd_entry),
        .entries  (entries)
    );

    // instruction fetch, load/store and TLBSRCH each get their own matcher
    tlb_lookup fetch_lookup_i (.entries(entries), .req(fetch_req), .rsp(fetch_rsp));
    tlb_lookup data_lookup_i  (.entries(entries), .req(data_req),  .rsp(data_rsp));
    tlb_lookup maint_lookup_i (.entries(entries), .req(srch_req),  .rsp(srch_rsp));

    tlb_op_fsm op_fsm_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_req    (cmd_req),
        .cmd        (cmd),
        .srch_rsp   (srch_rsp),
        .rd_entry   (rd_entry),
        .fill_index (fill_index),
        .cmd_ack    (cmd_ack),
        .cmd_rsp    (cmd_rsp),
        .srch_req   (srch_req),
        .wr_en      (wr_en),
        .wr_index   (wr_index),
        .wr_entry   (wr_entry),
        .inv_en     (inv_en),
        .inv_sel    (inv_sel),
        .rd_index   (rd_index),
        .fill_adv   (fill_adv)
    );

    tlb_fill_counter fill_counter_i (
        .clk   (clk),
        .rst_n (rst_n),
        .adv   (fill_adv),
        .index (fill_index)
    );

endmodule

// ==== verification/tlb_tb.sv ====
`timescale 1ns/1ps

module tlb_tb;

    localparam int CLK_PERIOD      = 10;
    localparam int WATCHDOG_CYCLES = 2000;
    localparam int ACK_TIMEOUT     = 20;

    logic                     clk;
    logic                     rst_n;
    tlb_pkg::tlb_search_req_t fetch_req;
    tlb_pkg::tlb_search_rsp_t fetch_rsp;
    tlb_pkg::tlb_search_req_t data_req;
    tlb_pkg::tlb_search_rsp_t data_rsp;
    logic                     cmd_req;
    tlb_pkg::tlb_cmd_t        cmd;
    logic                     cmd_ack;
    tlb_pkg::tlb_cmd_rsp_t    cmd_rsp;

    // expected TLB contents with ps kept as 12 or 21
    tlb_pkg::tlb_entry_t ref_tlb [tlb_pkg::TLB_NUM];

    int checks;
    int errors;
    int test_errors;

    tlb_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .fetch_req (fetch_req),
        .fetch_rsp (fetch_rsp),
        .data_req  (data_req),
        .data_rsp  (data_rsp),
        .cmd_req   (cmd_req),
        .cmd       (cmd),
        .cmd_ack   (cmd_ack),
        .cmd_rsp   (cmd_rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ack two cycles after req is first seen and gone one edge after req drops
    a_ack_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(cmd_req) |-> !cmd_ack ##1 !cmd_ack ##1 !cmd_ack ##1 cmd_ack
    ) else begin
        errors++;
        $display("Fail at %0t: cmd_ack did not rise two cycles after cmd_req", $time);
    end

    a_ack_release: assert property (
        @(posedge clk) disable iff (!rst_n)
        $fell(cmd_req) |-> cmd_ack ##1 !cmd_ack
    ) else begin
        errors++;
        $display("Fail at %0t: cmd_ack did not fall one edge after cmd_req", $time);
    end

    function automatic tlb_pkg::tlb_entry_t rand_entry(logic [3:0] slot, logic [9:0] asid);
        tlb_pkg::tlb_entry_t ent;
        int                  sel;
        ent.e    = 1'b1;
        ent.vppn = {6'($urandom), slot, 9'($urandom)};
        sel      = $urandom % 3;
        ent.ps   = (sel == 0) ? 6'd12 : (sel == 1) ? 6'd21 : 6'($urandom);
        ent.asid = asid;
        ent.g    = 1'($urandom);
        ent.page0 = 26'($urandom);
        ent.page1 = 26'($urandom);
        return ent;
    endfunction

    // stored view of an entry where anything but 21 becomes 12
    function automatic tlb_pkg::tlb_entry_t normalize(tlb_pkg::tlb_entry_t ent);
        tlb_pkg::tlb_entry_t n;
        n    = ent;
        n.ps = (ent.ps == 6'd21) ? 6'd21 : 6'd12;
        return n;
    endfunction

    function automatic tlb_pkg::tlb_search_rsp_t ref_search(tlb_pkg::tlb_search_req_t req);
        tlb_pkg::tlb_search_rsp_t r;
        logic                     big;
        r = '0;
        for (int i = 0; i < tlb_pkg::TLB_NUM; i++) begin
            big = (ref_tlb[i].ps == 6'd21);
            if (ref_tlb[i].e && ref_tlb[i].vppn[18:9] == req.vppn[18:9]
                    && (big || ref_tlb[i].vppn[8:0] == req.vppn[8:0])
                    && (ref_tlb[i].g || ref_tlb[i].asid == req.asid)) begin
                r.found = 1'b1;
                r.index = 4'(i);
                r.ps    = ref_tlb[i].ps;
                r.page  = (big ? req.vppn[8] : req.va_bit12) ? ref_tlb[i].page1
                                                             : ref_tlb[i].page0;
            end
        end
        return r;
    endfunction

    function automatic bit same_result(tlb_pkg::tlb_search_rsp_t got,
                                       tlb_pkg::tlb_search_rsp_t exp);
        if (got.found != exp.found) return 1'b0;
        if (!exp.found) return 1'b1;
        return got.index == exp.index && got.ps == exp.ps && got.page == exp.page;
    endfunction

    function automatic void apply_inv(tlb_pkg::tlb_inv_sel_t sel);
        logic gl;
        logic am;
        logic vm;
        logic kill;
        for (int i = 0; i < tlb_pkg::TLB_NUM; i++) begin
            gl = ref_tlb[i].g;
            am = (ref_tlb[i].asid == sel.asid);
            vm = (ref_tlb[i].vppn[18:9] == sel.vppn[18:9])
              && (ref_tlb[i].ps == 6'd21 || ref_tlb[i].vppn[8:0] == sel.vppn[8:0]);
            case (sel.op)
                5'd0, 5'd1: kill = 1'b1;
                5'd2:       kill = gl;
                5'd3:       kill = !gl;
                5'd4:       kill = !gl && am;
                5'd5:       kill = !gl && am && vm;
                5'd6:       kill = (gl || am) && vm;
                default:    kill = 1'b0;
            endcase
            if (kill) ref_tlb[i].e = 1'b0;
        end
    endfunction

    // one four-phase transaction on the maintenance port
    task automatic tlb_cmd(input tlb_pkg::tlb_cmd_kind_t kind, input tlb_pkg::tlb_cmd_arg_u arg,
                           input tlb_pkg::tlb_entry_t entry, output tlb_pkg::tlb_cmd_rsp_t rsp);
        int waited;
        @(negedge clk);
        cmd.kind  = kind;
        cmd.arg   = arg;
        cmd.entry = entry;
        cmd_req   = 1'b1;
        waited    = 0;
        while (!cmd_ack && waited < ACK_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!cmd_ack) begin
            errors++;
            $display("cmd_ack never came for command %s", kind.name());
        end
        rsp     = cmd_rsp;
        cmd_req = 1'b0;
        waited  = 0;
        while (cmd_ack && waited < ACK_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic write_entry(logic [3:0] idx, tlb_pkg::tlb_entry_t ent);
        tlb_pkg::tlb_cmd_arg_u arg;
        tlb_pkg::tlb_cmd_rsp_t rsp;
        arg           = '0;
        arg.idx.index = idx;
        tlb_cmd(tlb_pkg::WR, arg, ent, rsp);
        ref_tlb[idx] = normalize(ent);
    endtask

    task automatic read_and_check(logic [3:0] idx);
        tlb_pkg::tlb_cmd_arg_u arg;
        tlb_pkg::tlb_cmd_rsp_t rsp;
        arg           = '0;
        arg.idx.index = idx;
        tlb_cmd(tlb_pkg::RD, arg, '0, rsp);
        checks++;
        if (!ref_tlb[idx].e) begin
            assert (rsp.entry.e == 1'b0) else begin
                errors++;
                $display("Fail at %0t: entry %0d still valid", $time, idx);
            end
        end else begin
            assert (rsp.entry == ref_tlb[idx]) else begin
                errors++;
                $display("Fail at %0t: entry %0d read %h, expected %h",
                         $time, idx, rsp.entry, ref_tlb[idx]);
            end
        end
    endtask

    task automatic search_and_check(tlb_pkg::tlb_search_req_t key);
        tlb_pkg::tlb_search_rsp_t exp;
        @(negedge clk);
        fetch_req = key;
        data_req  = key;
        #1;
        exp = ref_search(key);
        checks++;
        assert (same_result(fetch_rsp, exp) && same_result(data_rsp, exp)) else begin
            errors++;
            $display("Fail at %0t: search vppn %h asid %h found %b/%b, expected %b idx %0d",
                     $time, key.vppn, key.asid, fetch_rsp.found, data_rsp.found,
                     exp.found, exp.index);
        end
    endtask

    task automatic report_test(string name);
        $display("test %s done, %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    initial begin
        tlb_pkg::tlb_search_req_t key;
        tlb_pkg::tlb_entry_t      ent;
        tlb_pkg::tlb_cmd_arg_u    arg;
        tlb_pkg::tlb_cmd_rsp_t    rsp;
        tlb_pkg::tlb_search_rsp_t exp;
        int                       j;
        int                       ops [8];

        void'($urandom(27463));
        clk         = 1'b0;
        rst_n       = 1'b0;
        cmd_req     = 1'b0;
        cmd         = '0;
        fetch_req   = '0;
        data_req    = '0;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        ops         = '{0, 1, 2, 3, 4, 5, 6, 9};
        for (int i = 0; i < tlb_pkg::TLB_NUM; i++) ref_tlb[i] = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        checks++;
        assert (cmd_ack == 1'b0) else begin
            errors++;
            $display("Fail at %0t: cmd_ack high after reset", $time);
        end
        report_test("handshake");

        for (int i = 0; i < tlb_pkg::TLB_NUM; i++) begin
            write_entry(4'(i), rand_entry(4'(i), 10'($urandom)));
        end
        for (int i = 0; i < tlb_pkg::TLB_NUM; i++) read_and_check(4'(i));
        report_test("write_read");

        for (int i = 0; i < tlb_pkg::TLB_NUM; i++) begin
            key.vppn     = ref_tlb[i].ps == 6'd21 ? {ref_tlb[i].vppn[18:9], 9'($urandom)}
                                                  : ref_tlb[i].vppn;
            key.va_bit12 = 1'($urandom);
            key.asid     = ref_tlb[i].asid;
            search_and_check(key);
            key.asid = ~ref_tlb[i].asid;
            search_and_check(key);
            // TLBSRCH with the same key, compared with the data port as well
            key.va_bit12 = 1'b0;
            key.asid     = ref_tlb[i].asid;
            search_and_check(key);
            exp       = ref_search(key);
            ent       = '0;
            ent.vppn  = key.vppn;
            ent.asid  = key.asid;
            tlb_cmd(tlb_pkg::SRCH, '0, ent, rsp);
            checks++;
            assert (rsp.found == exp.found && rsp.found == data_rsp.found
                    && (!exp.found || (rsp.index == exp.index && rsp.index == data_rsp.index)))
            else begin
                errors++;
                $display("Fail at %0t: TLBSRCH found %b idx %0d, expected %b idx %0d",
                         $time, rsp.found, rsp.index, exp.found, exp.index);
            end
        end
        report_test("search");

        for (int k = 0; k < 20; k++) begin
            ent = rand_entry(4'(k % 16), 10'($urandom));
            tlb_cmd(tlb_pkg::FILL, '0, ent, rsp);
            checks++;
            assert (rsp.index == 4'(k % 16)) else begin
                errors++;
                $display("Fail at %0t: fill %0d used slot %0d", $time, k, rsp.index);
            end
            ref_tlb[k % 16] = normalize(ent);
            read_and_check(4'(k % 16));
        end
        report_test("fill");

        foreach (ops[n]) begin
            for (int i = 0; i < tlb_pkg::TLB_NUM; i++) begin
                write_entry(4'(i), rand_entry(4'(i), 10'd1 + 10'($urandom % 2)));
            end
            j            = $urandom % tlb_pkg::TLB_NUM;
            arg          = '0;
            arg.inv.op   = 5'(ops[n]);
            arg.inv.asid = ref_tlb[j].asid;
            arg.inv.vppn = ref_tlb[j].vppn;
            tlb_cmd(tlb_pkg::INV, arg, '0, rsp);
            apply_inv(arg.inv);
            for (int i = 0; i < tlb_pkg::TLB_NUM; i++) begin
                read_and_check(4'(i));
                key.vppn     = ref_tlb[i].vppn;
                key.va_bit12 = 1'b0;
                key.asid     = ref_tlb[i].asid;
                search_and_check(key);
            end
        end
        report_test("invalidate");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule
